// File: cabacDecodeBin.f
+incdir+src
+incdir+dv
src/cabacTablesPkg.sv
src/cabacEnginePkg.sv
src/lpsRangeTable.sv
src/stateTransition.sv
src/binDecision.sv
src/renormalizer.sv
src/cabacDecodeBin.sv
dv/cabacDecodeBinTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cabacDecodeBin testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f cabacDecodeBin.f \
        --top-module cabacDecodeBinTb --Mdir obj_dir -o simv \
        && ./obj_dir/simv 2>&1 | tee sim.log \
        || { echo "build or simulation failed"; exit 1; }

grep -qx "TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: dv/cabacRefModel.svh
`ifndef CABAC_REF_MODEL_SVH
`define CABAC_REF_MODEL_SVH

// ----------------------------------------------------------------------
// standard tables, transcribed independently of the RTL
// ----------------------------------------------------------------------
// rangeTabLps, one row per state, columns are the range quarters
localparam int lpsTable [64][4] = '{
        '{128, 176, 208, 240}, '{128, 167, 197, 227}, '{128, 158, 187, 216},
        '{123, 150, 178, 205}, '{116, 142, 169, 195}, '{111, 135, 160, 185},
        '{105, 128, 152, 175}, '{100, 122, 144, 166}, '{ 95, 116, 137, 158},
        '{ 90, 110, 130, 150}, '{ 85, 104, 123, 142}, '{ 81,  99, 117, 135},
        '{ 77,  94, 111, 128}, '{ 73,  89, 105, 122}, '{ 69,  85, 100, 116},
        '{ 66,  80,  95, 110}, '{ 62,  76,  90, 104}, '{ 59,  72,  86,  99},
        '{ 56,  69,  81,  94}, '{ 53,  65,  77,  89}, '{ 51,  62,  73,  85},
        '{ 48,  59,  69,  80}, '{ 46,  56,  66,  76}, '{ 43,  53,  63,  72},
        '{ 41,  50,  59,  69}, '{ 39,  48,  56,  65}, '{ 37,  45,  54,  62},
        '{ 35,  43,  51,  59}, '{ 33,  41,  48,  56}, '{ 32,  39,  46,  53},
        '{ 30,  37,  43,  50}, '{ 29,  35,  41,  48}, '{ 27,  33,  39,  45},
        '{ 26,  31,  37,  43}, '{ 24,  30,  35,  41}, '{ 23,  28,  33,  39},
        '{ 22,  27,  32,  37}, '{ 21,  26,  30,  35}, '{ 20,  24,  29,  33},
        '{ 19,  23,  27,  31}, '{ 18,  22,  26,  30}, '{ 17,  21,  25,  28},
        '{ 16,  20,  23,  27}, '{ 15,  19,  22,  25}, '{ 14,  18,  21,  24},
        '{ 14,  17,  20,  23}, '{ 13,  16,  19,  22}, '{ 12,  15,  18,  21},
        '{ 12,  14,  17,  20}, '{ 11,  14,  16,  19}, '{ 11,  13,  15,  18},
        '{ 10,  12,  15,  17}, '{ 10,  12,  14,  16}, '{  9,  11,  13,  15},
        '{  9,  11,  12,  14}, '{  8,  10,  12,  14}, '{  8,   9,  11,  13},
        '{  7,   9,  11,  12}, '{  7,   9,  10,  12}, '{  7,   8,  10,  11},
        '{  6,   8,   9,  11}, '{  6,   7,   9,  10}, '{  6,   7,   8,   9},
        '{  2,   2,   2,   2}
};

localparam int lpsNextTable [64] = '{
         0,  0,  1,  2,  2,  4,  4,  5,  6,  7,  8,  9,  9, 11, 11, 12,
        13, 13, 15, 15, 16, 16, 18, 18, 19, 19, 21, 21, 22, 22, 23, 24,
        24, 25, 26, 26, 27, 27, 28, 29, 29, 30, 30, 30, 31, 32, 32, 33,
        33, 33, 34, 34, 35, 35, 35, 36, 36, 36, 37, 37, 37, 38, 38, 63
};

localparam int mpsNextTable [64] = '{
         1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15, 16,
        17, 18, 19, 20, 21, 22, 23, 24, 25, 26, 27, 28, 29, 30, 31, 32,
        33, 34, 35, 36, 37, 38, 39, 40, 41, 42, 43, 44, 45, 46, 47, 48,
        49, 50, 51, 52, 53, 54, 55, 56, 57, 58, 59, 60, 61, 62, 62, 63
};

// one decoded bin, then renormalization with bits taken msb first
function automatic void predictBin(
        input  int rangeIn, input int offsetIn, input int stateIn,
        input  int mpsIn, input int rbspIn,
        output int binVal, output int nextState, output int nextMps,
        output int newRange, output int newOffset, output int shift);
        int lps;
        int rangeMps;
        lps      = lpsTable[stateIn][(rangeIn >> 6) % 4];
        rangeMps = rangeIn - lps;
        if (offsetIn >= rangeMps) begin
                binVal    = 1 - mpsIn;
                newRange  = lps;
                newOffset = offsetIn - rangeMps;
                nextState = lpsNextTable[stateIn];
                nextMps   = (stateIn == 0) ? 1 - mpsIn : mpsIn;
        end else begin
                binVal    = mpsIn;
                newRange  = rangeMps;
                newOffset = offsetIn;
                nextState = mpsNextTable[stateIn];
                nextMps   = mpsIn;
        end
        shift = 0;
        while (newRange < 256) begin
                newRange  = newRange * 2;
                newOffset = newOffset * 2 + ((rbspIn >> (5 - shift)) & 1);
                shift++;
        end
endfunction

`endif

// File: dv/cabacDecodeBinTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cabacEngine_defines.svh"

module cabacDecodeBinTb;

        localparam int waitLimit   = 20;   // cycles per handshake phase
        localparam int randomCount = 300;

        logic                           clk;
        logic                           i_reset;
        logic [`CABAC_RANGE_W-1:0]      i_range;
        logic [`CABAC_RANGE_W-1:0]      i_offset;
        logic [`CABAC_STATE_W-1:0]      i_state;
        logic                           i_valMps;
        logic [`CABAC_RBSP_W-1:0]       i_rbsp;
        logic                           i_req;
        logic                           o_ack;
        logic                           o_binVal;
        logic [`CABAC_STATE_W-1:0]      o_state;
        logic                           o_valMps;
        logic [`CABAC_RANGE_W-1:0]      o_range;
        logic [`CABAC_RANGE_W-1:0]      o_offset;
        logic [`CABAC_SHIFT_W-1:0]      o_shiftLen;

        int curRange;   // request in flight
        int curOffset;
        int curState;
        int curMps;
        int curRbsp;
        int checkCount;
        int errorCount;
        int testChecks;
        int testErrors;
        int riseCycles;
        int fallCycles;
        int seedValue;
        int r;
        bit timedOut;   // handshake stuck, remaining transactions skipped

        `include "cabacRefModel.svh"

        cabacDecodeBin DUT (.*);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic void checkValue(input string name, input int got, input int exp);
                checkCount++;
                assert (got == exp) else begin
                        $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
                        errorCount++;
                end
        endfunction

        // ----------------------------------------------------------------------
        // compare every acknowledged cycle with the reference
        // ----------------------------------------------------------------------
        always @(negedge clk) begin : compareResults
                int expBin;
                int expState;
                int expMps;
                int expRange;
                int expOffset;
                int expShift;
                if (!i_reset && o_ack) begin
                        predictBin(curRange, curOffset, curState, curMps, curRbsp,
                                   expBin, expState, expMps, expRange, expOffset, expShift);
                        checkValue("o_binVal", int'(o_binVal), expBin);
                        checkValue("o_state", int'(o_state), expState);
                        checkValue("o_valMps", int'(o_valMps), expMps);
                        checkValue("o_range", int'(o_range), expRange);
                        checkValue("o_offset", int'(o_offset), expOffset);
                        checkValue("o_shiftLen", int'(o_shiftLen), expShift);
                end
        end

        task automatic waitAck(input logic level, input string what, output int cycles);
                cycles = 0;
                if (timedOut) begin
                        return;
                end
                do begin
                        @(negedge clk);
                        cycles++;
                end while (o_ack != level && cycles < waitLimit);
                if (o_ack != level) begin
                        $display("timeout: %s within %0d cycles", what, waitLimit);
                        errorCount++;
                        timedOut = 1'b1;
                end
        endtask

        // full four-phase cycle, req held a few extra cycles when asked
        task automatic runTransaction(input int rangeIn, input int offsetIn, input int stateIn,
                                      input int mpsIn, input int rbspIn, input int holdCycles);
                if (timedOut) begin
                        return;
                end
                curRange  = rangeIn;
                curOffset = offsetIn;
                curState  = stateIn;
                curMps    = mpsIn;
                curRbsp   = rbspIn;
                i_range   = 9'(rangeIn);
                i_offset  = 9'(offsetIn);
                i_state   = 6'(stateIn);
                i_valMps  = 1'(mpsIn);
                i_rbsp    = 6'(rbspIn);
                i_req     = 1'b1;
                waitAck(1'b1, "o_ack did not rise after the request", riseCycles);
                if (!timedOut) begin
                        repeat (holdCycles) begin
                                @(negedge clk);
                                assert (o_ack) else begin
                                        $display("o_ack dropped at %0t while i_req was still high",
                                                 $time);
                                        errorCount++;
                                end
                        end
                end
                i_req    = 1'b0;
                i_range  = 9'($urandom);   // results must not follow the inputs
                i_offset = 9'($urandom);
                i_state  = 6'($urandom);
                i_rbsp   = 6'($urandom);
                waitAck(1'b0, "o_ack did not fall after the request dropped", fallCycles);
        endtask

        task automatic reportTest(input string name);
                $display("test %s: %0d checks, %0d errors", name,
                         checkCount - testChecks, errorCount - testErrors);
                testChecks = checkCount;
                testErrors = errorCount;
        endtask

        initial begin
                seedValue  = $urandom(21780);
                checkCount = 0;
                errorCount = 0;
                testChecks = 0;
                testErrors = 0;
                timedOut   = 1'b0;
                i_reset    = 1'b1;
                i_req      = 1'b0;
                i_range    = 9'd256;
                i_offset   = '0;
                i_state    = '0;
                i_valMps   = 1'b0;
                i_rbsp     = '0;
                repeat (8) @(negedge clk);
                i_reset = 1'b0;

                checkCount++;
                assert (o_ack == 1'b0) else begin
                        $display("o_ack is high right after reset");
                        errorCount++;
                end
                runTransaction(300, 40, 5, 0, 0, 3);
                checkValue("ack rise cycles", riseCycles, 1);
                checkValue("ack fall cycles", fallCycles, 1);
                reportTest("handshake");

                runTransaction(510, 20, 10, 1, 6'b010101, 1);
                checkValue("o_binVal", int'(o_binVal), 1);
                checkValue("o_state", int'(o_state), 11);
                checkValue("o_shiftLen", int'(o_shiftLen), 0);
                reportTest("mps without renorm");

                runTransaction(256, 200, 0, 0, 6'b101101, 0);
                checkValue("o_range", int'(o_range), 256);
                checkValue("o_offset", int'(o_offset), 145);
                checkValue("o_shiftLen", int'(o_shiftLen), 1);
                runTransaction(300, 295, 62, 1, 6'b110011, 0);
                checkValue("o_range", int'(o_range), 6 << 6);
                checkValue("o_offset low bits", int'(o_offset) % 64, 6'b110011);
                checkValue("o_shiftLen", int'(o_shiftLen), 6);
                reportTest("lps with renorm");

                runTransaction(400, 250, 0, 1, 0, 0);   // lps at state 0
                checkValue("o_valMps", int'(o_valMps), 0);
                checkValue("o_binVal", int'(o_binVal), 0);
                runTransaction(480, 5, 62, 0, 0, 0);
                checkValue("o_state", int'(o_state), 62);
                runTransaction(300, 10, 63, 1, 0, 0);
                checkValue("o_state", int'(o_state), 63);
                checkValue("o_range", int'(o_range), 298);
                reportTest("context edges");

                for (int n = 0; n < randomCount; n++) begin
                        r = 256 + int'($urandom % 255);
                        runTransaction(r, int'($urandom % r), int'($urandom % 63),
                                       int'($urandom % 2), int'($urandom % 64), 0);
                end
                reportTest("random legal");

                $display("total: %0d checks, %0d errors", checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("TESTS PASSED");
                end else begin
                        $display("TESTS FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: src/cabacDecodeBin.sv
`timescale 1ns/1ps
`default_nettype none

`include "cabacEngine_defines.svh"

module cabacDecodeBin (
        input  wire                             clk,
        input  wire                             i_reset,
        input  wire cabacEnginePkg::rangeT      i_range,
        input  wire cabacEnginePkg::offsetT     i_offset,
        input  wire cabacTablesPkg::stateT      i_state,
        input  wire                             i_valMps,
        input  wire cabacEnginePkg::rbspT       i_rbsp,
        input  wire                             i_req,
        output logic                            o_ack,
        output logic                            o_binVal,
        output cabacTablesPkg::stateT           o_state,
        output logic                            o_valMps,
        output cabacEnginePkg::rangeT           o_range,
        output cabacEnginePkg::offsetT          o_offset,
        output cabacEnginePkg::shiftT           o_shiftLen
);

        cabacTablesPkg::lpsRangeT       lpsRange;
        cabacTablesPkg::stateT          mpsNext;
        cabacTablesPkg::stateT          lpsNext;
        cabacEnginePkg::rangeT          rangeRaw;
        cabacEnginePkg::offsetT         offsetRaw;
        cabacEnginePkg::rbspT           rbspHeld;

        // ----------------------------------------------------------------------
        // table lookups on the live request
        // ----------------------------------------------------------------------
        lpsRangeTable uLpsRange (
                .i_range        (i_range),
                .i_state        (i_state),
                .o_lpsRange     (lpsRange)
        );

        stateTransition uStateTrans (
                .i_state        (i_state),
                .o_mpsNext      (mpsNext),
                .o_lpsNext      (lpsNext)
        );

        binDecision uDecision (
                .clk            (clk),
                .i_reset        (i_reset),
                .i_req          (i_req),
                .i_range        (i_range),
                .i_offset       (i_offset),
                .i_state        (i_state),
                .i_valMps       (i_valMps),
                .i_rbsp         (i_rbsp),
                .i_lpsRange     (lpsRange),
                .i_mpsNext      (mpsNext),
                .i_lpsNext      (lpsNext),
                .o_ack          (o_ack),
                .o_binVal       (o_binVal),
                .o_state        (o_state),
                .o_valMps       (o_valMps),
                .o_rangeRaw     (rangeRaw),
                .o_offsetRaw    (offsetRaw),
                .o_rbsp         (rbspHeld)
        );

        renormalizer uRenorm (
                .i_rangeRaw     (rangeRaw),
                .i_offsetRaw    (offsetRaw),
                .i_rbsp         (rbspHeld),
                .o_range        (o_range),
                .o_offset       (o_offset),
                .o_shiftLen     (o_shiftLen)
        );

        // normal form on every acknowledged result
        rangeNormalized: assert property (@(posedge clk) disable iff (i_reset)
                o_ack |-> o_range[`CABAC_RANGE_W-1]);

endmodule

`default_nettype wire

// File: src/renormalizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cabacEngine_defines.svh"

module renormalizer (
        input  wire cabacEnginePkg::rangeT      i_rangeRaw,
        input  wire cabacEnginePkg::offsetT     i_offsetRaw,
        input  wire cabacEnginePkg::rbspT       i_rbsp,
        output cabacEnginePkg::rangeT           o_range,
        output cabacEnginePkg::offsetT          o_offset,
        output cabacEnginePkg::shiftT           o_shiftLen
);

        localparam int winW = `CABAC_RANGE_W + `CABAC_RBSP_W;

        logic [winW-1:0] window;   // offset with refill bits below
        logic [winW-1:0] shifted;

        // leading zeros, at most six for a legal LPS range
        always_comb begin
                casez (i_rangeRaw[8:2])
                7'b1??_???? : o_shiftLen = 3'd0;
                7'b01?_???? : o_shiftLen = 3'd1;
                7'b001_???? : o_shiftLen = 3'd2;
                7'b000_1??? : o_shiftLen = 3'd3;
                7'b000_01?? : o_shiftLen = 3'd4;
                7'b000_001? : o_shiftLen = 3'd5;
                7'b000_0001 : o_shiftLen = 3'd6;
                default     : o_shiftLen = 3'd0;
                endcase
        end

        assign o_range = i_rangeRaw << o_shiftLen;

        assign window   = {i_offsetRaw, i_rbsp};
        assign shifted  = window << o_shiftLen;
        assign o_offset = shifted[winW-1 -: `CABAC_RANGE_W];  // top bits, refilled

endmodule

`default_nettype wire

// File: src/binDecision.sv
`timescale 1ns/1ps
`default_nettype none

module binDecision (
        input  wire                             clk,
        input  wire                             i_reset,
        input  wire                             i_req,
        input  wire cabacEnginePkg::rangeT      i_range,
        input  wire cabacEnginePkg::offsetT     i_offset,
        input  wire cabacTablesPkg::stateT      i_state,
        input  wire                             i_valMps,
        input  wire cabacEnginePkg::rbspT       i_rbsp,
        input  wire cabacTablesPkg::lpsRangeT   i_lpsRange,
        input  wire cabacTablesPkg::stateT      i_mpsNext,
        input  wire cabacTablesPkg::stateT      i_lpsNext,
        output logic                            o_ack,
        output logic                            o_binVal,
        output cabacTablesPkg::stateT           o_state,
        output logic                            o_valMps,
        output cabacEnginePkg::rangeT           o_rangeRaw,
        output cabacEnginePkg::offsetT          o_offsetRaw,
        output cabacEnginePkg::rbspT            o_rbsp
);

        logic                           accept;
        logic                           isLps;
        cabacEnginePkg::rangeT          rangeDiffR;  // range - lps
        cabacEnginePkg::offsetDiffT     offDiffR;    // offset + lps - range
        cabacTablesPkg::lpsRangeT       lpsR;
        cabacTablesPkg::stateT          mpsNextR;
        cabacTablesPkg::stateT          lpsNextR;
        logic                           valMpsR;
        logic                           stateZeroR;

        assign accept = i_req & ~o_ack;

        // ----------------------------------------------------------------------
        // four-phase handshake
        // ----------------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (i_reset) begin
                        o_ack <= 1'b0;
                end else if (accept) begin
                        o_ack <= 1'b1;
                end else if (!i_req) begin
                        o_ack <= 1'b0;
                end
        end

        // the one pipeline stage, held until the next request
        always_ff @(posedge clk) begin
                if (accept) begin
                        rangeDiffR <= i_range - {1'b0, i_lpsRange};
                        offDiffR   <= $signed({1'b0, i_offset}) + $signed({2'b00, i_lpsRange})
                                      - $signed({1'b0, i_range});
                        lpsR       <= i_lpsRange;
                        mpsNextR   <= i_mpsNext;
                        lpsNextR   <= i_lpsNext;
                        valMpsR    <= i_valMps;
                        stateZeroR <= (i_state == '0);
                        o_rbsp     <= i_rbsp;
                end
        end

        // ----------------------------------------------------------------------
        // decision
        // ----------------------------------------------------------------------
        assign isLps = ~offDiffR[$bits(offDiffR)-1];

        always_comb begin
                if (isLps) begin
                        o_binVal    = ~valMpsR;
                        o_rangeRaw  = {1'b0, lpsR};
                        o_offsetRaw = offDiffR[$bits(o_offsetRaw)-1:0];
                        o_state     = lpsNextR;
                        o_valMps    = valMpsR ^ stateZeroR;  // flip at state 0
                end else begin
                        o_binVal    = valMpsR;
                        o_rangeRaw  = rangeDiffR;
                        // original offset, recovered from the two differences
                        o_offsetRaw = offDiffR[$bits(o_offsetRaw)-1:0] + rangeDiffR;
                        o_state     = mpsNextR;
                        o_valMps    = valMpsR;
                end
        end

        // requester keeps i_req up until acknowledged
        reqHeldForAck: assert property (@(posedge clk) disable iff (i_reset)
                $fell(i_req) |-> o_ack);

        offsetInRange: assert property (@(posedge clk) disable iff (i_reset)
                o_ack |-> (o_offsetRaw < o_rangeRaw));

endmodule

`default_nettype wire

// File: src/stateTransition.sv
`timescale 1ns/1ps
`default_nettype none

`include "cabacEngine_defines.svh"

module stateTransition (
        input  wire cabacTablesPkg::stateT      i_state,
        output cabacTablesPkg::stateT           o_mpsNext,
        output cabacTablesPkg::stateT           o_lpsNext
);

        localparam cabacTablesPkg::stateT satState   = `CABAC_STATE_SAT;
        localparam cabacTablesPkg::stateT fixedState = `CABAC_STATE_FIXED;

        // transIdxLps, eight states per line
        localparam cabacTablesPkg::stateT lpsNextTab [64] = '{
                 0,  0,  1,  2,  2,  4,  4,  5,
                 6,  7,  8,  9,  9, 11, 11, 12,
                13, 13, 15, 15, 16, 16, 18, 18,
                19, 19, 21, 21, 22, 22, 23, 24,
                24, 25, 26, 26, 27, 27, 28, 29,
                29, 30, 30, 30, 31, 32, 32, 33,
                33, 33, 34, 34, 35, 35, 35, 36,
                36, 36, 37, 37, 37, 38, 38, 63
        };

        always_comb begin
                if (i_state == fixedState) begin
                        o_mpsNext = fixedState;
                end else if (i_state == satState) begin
                        o_mpsNext = satState;  // saturate, no wrap into 63
                end else begin
                        o_mpsNext = i_state + 1'b1;
                end
        end

        assign o_lpsNext = lpsNextTab[i_state];

endmodule

`default_nettype wire

// File: src/lpsRangeTable.sv
`timescale 1ns/1ps
`default_nettype none

module lpsRangeTable (
        input  wire cabacEnginePkg::rangeT      i_range,
        input  wire cabacTablesPkg::stateT      i_state,
        output cabacTablesPkg::lpsRangeT        o_lpsRange
);

        cabacTablesPkg::qIdxT     qIdx;
        cabacTablesPkg::lpsRangeT row [4];  // one state, all quarters

        assign qIdx = i_range[7:6];

        always_comb begin
                case (i_state)
                6'd00 : row = '{128, 176, 208, 240};
                6'd01 : row = '{128, 167, 197, 227};
                6'd02 : row = '{128, 158, 187, 216};
                6'd03 : row = '{123, 150, 178, 205};
                6'd04 : row = '{116, 142, 169, 195};
                6'd05 : row = '{111, 135, 160, 185};
                6'd06 : row = '{105, 128, 152, 175};
                6'd07 : row = '{100, 122, 144, 166};
                6'd08 : row = '{ 95, 116, 137, 158};
                6'd09 : row = '{ 90, 110, 130, 150};
                6'd10 : row = '{ 85, 104, 123, 142};
                6'd11 : row = '{ 81,  99, 117, 135};
                6'd12 : row = '{ 77,  94, 111, 128};
                6'd13 : row = '{ 73,  89, 105, 122};
                6'd14 : row = '{ 69,  85, 100, 116};
                6'd15 : row = '{ 66,  80,  95, 110};
                6'd16 : row = '{ 62,  76,  90, 104};
                6'd17 : row = '{ 59,  72,  86,  99};
                6'd18 : row = '{ 56,  69,  81,  94};
                6'd19 : row = '{ 53,  65,  77,  89};
                6'd20 : row = '{ 51,  62,  73,  85};
                6'd21 : row = '{ 48,  59,  69,  80};
                6'd22 : row = '{ 46,  56,  66,  76};
                6'd23 : row = '{ 43,  53,  63,  72};
                6'd24 : row = '{ 41,  50,  59,  69};
                6'd25 : row = '{ 39,  48,  56,  65};
                6'd26 : row = '{ 37,  45,  54,  62};
                6'd27 : row = '{ 35,  43,  51,  59};
                6'd28 : row = '{ 33,  41,  48,  56};
                6'd29 : row = '{ 32,  39,  46,  53};
                6'd30 : row = '{ 30,  37,  43,  50};
                6'd31 : row = '{ 29,  35,  41,  48};
                6'd32 : row = '{ 27,  33,  39,  45};
                6'd33 : row = '{ 26,  31,  37,  43};
                6'd34 : row = '{ 24,  30,  35,  41};
                6'd35 : row = '{ 23,  28,  33,  39};
                6'd36 : row = '{ 22,  27,  32,  37};
                6'd37 : row = '{ 21,  26,  30,  35};
                6'd38 : row = '{ 20,  24,  29,  33};
                6'd39 : row = '{ 19,  23,  27,  31};
                6'd40 : row = '{ 18,  22,  26,  30};
                6'd41 : row = '{ 17,  21,  25,  28};
                6'd42 : row = '{ 16,  20,  23,  27};
                6'd43 : row = '{ 15,  19,  22,  25};
                6'd44 : row = '{ 14,  18,  21,  24};
                6'd45 : row = '{ 14,  17,  20,  23};
                6'd46 : row = '{ 13,  16,  19,  22};
                6'd47 : row = '{ 12,  15,  18,  21};
                6'd48 : row = '{ 12,  14,  17,  20};
                6'd49 : row = '{ 11,  14,  16,  19};
                6'd50 : row = '{ 11,  13,  15,  18};
                6'd51 : row = '{ 10,  12,  15,  17};
                6'd52 : row = '{ 10,  12,  14,  16};
                6'd53 : row = '{  9,  11,  13,  15};
                6'd54 : row = '{  9,  11,  12,  14};
                6'd55 : row = '{  8,  10,  12,  14};
                6'd56 : row = '{  8,   9,  11,  13};
                6'd57 : row = '{  7,   9,  11,  12};
                6'd58 : row = '{  7,   9,  10,  12};
                6'd59 : row = '{  7,   8,  10,  11};
                6'd60 : row = '{  6,   8,   9,  11};
                6'd61 : row = '{  6,   7,   9,  10};
                6'd62 : row = '{  6,   7,   8,   9};
                default : row = '{  2,   2,   2,   2};  // state 63
                endcase
        end

        assign o_lpsRange = row[qIdx];

endmodule

`default_nettype wire

// File: src/cabacEnginePkg.sv
`default_nettype none

`include "cabacEngine_defines.svh"

// arithmetic side of the engine

package cabacEnginePkg;

        typedef logic [`CABAC_RANGE_W-1:0] rangeT;
        typedef logic [`CABAC_RANGE_W-1:0] offsetT;
        typedef logic [`CABAC_RBSP_W-1:0]  rbspT;   // msb is the next bit
        typedef logic [`CABAC_SHIFT_W-1:0] shiftT;

        // sign bit picks MPS (negative) or LPS
        typedef logic signed [`CABAC_RANGE_W:0] offsetDiffT;

endpackage

`default_nettype wire

// File: src/cabacTablesPkg.sv
`default_nettype none

`include "cabacEngine_defines.svh"

// table side of the engine: context state and LPS sub-range

package cabacTablesPkg;

        typedef logic [`CABAC_STATE_W-1:0] stateT;     // probability state
        typedef logic [`CABAC_LPS_W-1:0]   lpsRangeT;  // LPS sub-range

        // range quarter, bits 7:6 of the range
        typedef logic [1:0]                qIdxT;

endpackage

`default_nettype wire

// File: src/cabacEngine_defines.svh
`ifndef CABAC_ENGINE_DEFINES_SVH
`define CABAC_ENGINE_DEFINES_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define CABAC_RANGE_W     9     // range and offset
`define CABAC_STATE_W     6
`define CABAC_LPS_W       8
`define CABAC_RBSP_W      6     // upcoming bitstream bits
`define CABAC_SHIFT_W     3

// ----------------------------------------------------------------------
// context limits
// ----------------------------------------------------------------------
`define CABAC_STATE_SAT   62    // highest adaptive state
`define CABAC_STATE_FIXED 63    // never adapts

`endif
